// ==== mr_cfg.svh ====
/*
 * MR request engine configuration
 * widths, depths and MPT region geometry shared by all blocks
 */
`ifndef MR_CFG_SVH
`define MR_CFG_SVH

// request tag space
`define MR_TAG_W            5
`define MR_TAG_NUM          32

// command fields
`define MR_LKEY_W           32
`define MR_HEAD_W           64

// address widths
`define ICM_ADDR_W          64
`define PHY_ADDR_W          64

// mpt table, index is the low lkey bits
`define MPT_IDX_W           6
`define MPT_ENTRY_NUM       64

// mpt region in icm space, 64 byte slots
`define MPT_ICM_BASE        64'h0000_0000_0040_0000
`define MPT_SLOT_SIZE_LOG   6

// get queue towards icm cache
`define GET_FIFO_DEPTH      4
`define GET_FIFO_DEPTH_LOG  2

`endif

// ==== mr_pkg.sv ====
/*
 * MR request engine types
 * vector typedefs and controller state encoding
 */
`default_nettype none

`include "mr_cfg.svh"

package mr_pkg;

    // request tag, indexes the request buffer
    typedef logic [`MR_TAG_W-1:0]    req_tag_t;

    // memory key of the command
    typedef logic [`MR_LKEY_W-1:0]   lkey_t;

    // command head word kept while the request is outstanding
    typedef logic [`MR_HEAD_W-1:0]   mr_head_t;

    // mpt table index
    typedef logic [`MPT_IDX_W-1:0]   mpt_idx_t;

    typedef logic [`ICM_ADDR_W-1:0]  icm_addr_t;
    typedef logic [`PHY_ADDR_W-1:0]  phy_addr_t;

    // request controller fsm
    typedef enum logic [1:0] {
        IDLE,
        ADDR_REQ,
        ADDR_RSP,
        MPT_GET
    } mpt_state_t;

endpackage

`default_nettype wire

// ==== icm_mapping_table.sv ====
/*
 * ICM mapping table
 * maps an MPT index to its ICM slot address and loaded physical address
 */
`timescale 1ns/1ps
`default_nettype none

`include "mr_cfg.svh"

module icm_mapping_table import mr_pkg::*; (
    input  wire         clk,
    input  wire         rst,

    // load port
    input  wire         map_wr_en,
    input  mpt_idx_t    map_wr_idx,
    input  phy_addr_t   map_wr_phy_addr,
    input  wire         map_wr_valid,

    // lookup request
    input  wire         lookup_valid,
    input  mpt_idx_t    lookup_idx,
    output logic        lookup_ready,

    // registered response slot
    output logic        rsp_valid,
    output logic        rsp_hit,
    output icm_addr_t   rsp_icm_addr,
    output phy_addr_t   rsp_phy_addr,
    input  wire         rsp_ready
);

    phy_addr_t                  phy_mem [`MPT_ENTRY_NUM];
    logic [`MPT_ENTRY_NUM-1:0]  entry_valid;

    logic       lookup_fire;
    icm_addr_t  lookup_icm_addr;

    // single response slot
    assign lookup_ready = !rsp_valid;
    assign lookup_fire  = lookup_valid && lookup_ready;

    // slot address from the index, no storage needed
    assign lookup_icm_addr = icm_addr_t'(`MPT_ICM_BASE)
                           + (icm_addr_t'(lookup_idx) << `MPT_SLOT_SIZE_LOG);

    // entry valid bits, cleared on write with map_wr_valid low
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            entry_valid <= '0;
        end else if (map_wr_en) begin
            entry_valid[map_wr_idx] <= map_wr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (map_wr_en) begin
            phy_mem[map_wr_idx] <= map_wr_phy_addr;
        end
    end

    // response held until rsp_ready
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_valid <= 1'b0;
            rsp_hit   <= 1'b0;
        end else if (lookup_fire) begin
            rsp_valid <= 1'b1;
            rsp_hit   <= entry_valid[lookup_idx];
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    // address payload
    always_ff @(posedge clk) begin
        if (lookup_fire) begin
            rsp_icm_addr <= lookup_icm_addr;
            rsp_phy_addr <= phy_mem[lookup_idx];
        end
    end

endmodule

`default_nettype wire

// ==== mr_req_buffer.sv ====
/*
 * MR request buffer
 * tag indexed command heads with busy bits and completion read-out
 */
`timescale 1ns/1ps
`default_nettype none

`include "mr_cfg.svh"

module mr_req_buffer import mr_pkg::*; (
    input  wire         clk,
    input  wire         rst,

    input  wire         buf_wen,
    input  req_tag_t    buf_tag,
    input  mr_head_t    buf_head,

    input  req_tag_t    query_tag,
    output logic        tag_busy,

    input  wire         cpl_valid,
    input  req_tag_t    cpl_tag,
    output logic        cpl_head_valid,
    output mr_head_t    cpl_head
);

    mr_head_t               head_mem [`MR_TAG_NUM];
    logic [`MR_TAG_NUM-1:0] busy;

    assign tag_busy = busy[query_tag];

    // completion clears, write sets, write wins on the same tag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy           <= '0;
            cpl_head_valid <= 1'b0;
        end else begin
            cpl_head_valid <= cpl_valid && busy[cpl_tag];
            if (cpl_valid) begin
                busy[cpl_tag] <= 1'b0;
            end
            if (buf_wen) begin
                busy[buf_tag] <= 1'b1;
            end
        end
    end

    // head storage and completion read
    always_ff @(posedge clk) begin
        if (buf_wen) begin
            head_mem[buf_tag] <= buf_head;
        end
        if (cpl_valid) begin
            cpl_head <= head_mem[cpl_tag];
        end
    end

endmodule

`default_nettype wire

// ==== icm_get_queue.sv ====
/*
 * ICM get request queue
 * small FIFO that absorbs back-pressure from the ICM cache
 */
`timescale 1ns/1ps
`default_nettype none

`include "mr_cfg.svh"

module icm_get_queue import mr_pkg::*; (
    input  wire         clk,
    input  wire         rst,

    // push side
    input  wire         get_push,
    input  req_tag_t    get_tag,
    input  icm_addr_t   get_icm_addr,
    input  phy_addr_t   get_phy_addr,
    output logic        get_full,

    // pop side
    output logic        icm_get_valid,
    output req_tag_t    icm_get_tag,
    output icm_addr_t   icm_get_icm_addr,
    output phy_addr_t   icm_get_phy_addr,
    input  wire         icm_get_ready
);

    localparam logic [`GET_FIFO_DEPTH_LOG:0] FIFO_DEPTH = `GET_FIFO_DEPTH;

    req_tag_t   tag_mem [`GET_FIFO_DEPTH];
    icm_addr_t  icm_mem [`GET_FIFO_DEPTH];
    phy_addr_t  phy_mem [`GET_FIFO_DEPTH];

    // pointers wrap, depth is a power of two
    logic [`GET_FIFO_DEPTH_LOG-1:0] wr_ptr;
    logic [`GET_FIFO_DEPTH_LOG-1:0] rd_ptr;
    logic [`GET_FIFO_DEPTH_LOG:0]   count;

    logic do_push;
    logic do_pop;

    assign get_full      = (count == FIFO_DEPTH);
    assign icm_get_valid = (count != '0);

    assign do_push = get_push && !get_full;
    assign do_pop  = icm_get_valid && icm_get_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop keeps the count
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            tag_mem[wr_ptr] <= get_tag;
            icm_mem[wr_ptr] <= get_icm_addr;
            phy_mem[wr_ptr] <= get_phy_addr;
        end
    end

    // head of queue, first word fall-through
    assign icm_get_tag      = tag_mem[rd_ptr];
    assign icm_get_icm_addr = icm_mem[rd_ptr];
    assign icm_get_phy_addr = phy_mem[rd_ptr];

endmodule

`default_nettype wire

// ==== mpt_req_ctl.sv ====
/*
 * MPT request controller
 * accepts MR commands, looks up the MPT entry and pushes one ICM get request
 */
`timescale 1ns/1ps
`default_nettype none

`include "mr_cfg.svh"

module mpt_req_ctl import mr_pkg::*; (
    input  wire         clk,
    input  wire         rst,

    // command port
    input  wire         mr_req_valid,
    output logic        mr_req_ready,
    input  req_tag_t    mr_req_tag,
    input  lkey_t       mr_req_lkey,
    input  mr_head_t    mr_req_head,

    // busy status of mr_req_tag
    input  wire         tag_busy,

    // lookup request
    output logic        lookup_valid,
    output mpt_idx_t    lookup_idx,
    input  wire         lookup_ready,

    // lookup response
    input  wire         rsp_valid,
    input  wire         rsp_hit,
    input  icm_addr_t   rsp_icm_addr,
    input  phy_addr_t   rsp_phy_addr,
    output logic        rsp_ready,

    // request buffer write
    output logic        buf_wen,
    output req_tag_t    buf_tag,
    output mr_head_t    buf_head,

    // get queue push
    output logic        get_push,
    output req_tag_t    get_tag,
    output icm_addr_t   get_icm_addr,
    output phy_addr_t   get_phy_addr,
    input  wire         get_full,

    output logic        mr_req_err
);

    mpt_state_t state_q;
    mpt_state_t state_d;

    // command fields held for the whole sequence
    req_tag_t   tag_q;
    mpt_idx_t   idx_q;
    mr_head_t   head_q;

    // addresses from the lookup response
    icm_addr_t  icm_q;
    phy_addr_t  phy_q;

    logic       req_fire;

    // a new command needs an idle fsm and a free tag
    assign mr_req_ready = (state_q == IDLE) && !tag_busy;
    assign req_fire     = mr_req_valid && mr_req_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_fire) begin
                    state_d = ADDR_REQ;
                end
            end
            // lookup_valid is held high here
            ADDR_REQ: begin
                if (lookup_ready) begin
                    state_d = ADDR_RSP;
                end
            end
            // miss drops the command
            ADDR_RSP: begin
                if (rsp_valid) begin
                    state_d = rsp_hit ? MPT_GET : IDLE;
                end
            end
            // stall while the get queue is full
            MPT_GET: begin
                if (!get_full) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // latch command on acceptance
    always_ff @(posedge clk) begin
        if (req_fire) begin
            tag_q  <= mr_req_tag;
            idx_q  <= mr_req_lkey[`MPT_IDX_W-1:0];
            head_q <= mr_req_head;
        end
    end

    // latch translated addresses
    always_ff @(posedge clk) begin
        if (state_q == ADDR_RSP && rsp_valid) begin
            icm_q <= rsp_icm_addr;
            phy_q <= rsp_phy_addr;
        end
    end

    assign lookup_valid = (state_q == ADDR_REQ);
    assign lookup_idx   = idx_q;
    assign rsp_ready    = (state_q == ADDR_RSP);

    // one cycle pulse, the response is consumed in this cycle
    assign mr_req_err = (state_q == ADDR_RSP) && rsp_valid && !rsp_hit;

    // buffer write and push share the same edge
    assign get_push     = (state_q == MPT_GET) && !get_full;
    assign buf_wen      = get_push;
    assign buf_tag      = tag_q;
    assign buf_head     = head_q;
    assign get_tag      = tag_q;
    assign get_icm_addr = icm_q;
    assign get_phy_addr = phy_q;

endmodule

`default_nettype wire

// ==== mr_req_top.sv ====
/*
 * MR request generation top
 * controller with mapping table, request buffer and get queue
 */
`timescale 1ns/1ps
`default_nettype none

`include "mr_cfg.svh"

module mr_req_top import mr_pkg::*; (
    input  wire         clk,
    input  wire         rst,

    // command port
    input  wire         mr_req_valid,
    output logic        mr_req_ready,
    input  req_tag_t    mr_req_tag,
    input  lkey_t       mr_req_lkey,
    input  mr_head_t    mr_req_head,
    output logic        mr_req_err,

    // mapping table load
    input  wire         map_wr_en,
    input  mpt_idx_t    map_wr_idx,
    input  phy_addr_t   map_wr_phy_addr,
    input  wire         map_wr_valid,

    // completion
    input  wire         cpl_valid,
    input  req_tag_t    cpl_tag,
    output logic        cpl_head_valid,
    output mr_head_t    cpl_head,

    // get requests to icm cache
    output logic        icm_get_valid,
    output req_tag_t    icm_get_tag,
    output icm_addr_t   icm_get_icm_addr,
    output phy_addr_t   icm_get_phy_addr,
    input  wire         icm_get_ready
);

    // lookup channel
    logic       lookup_valid;
    mpt_idx_t   lookup_idx;
    logic       lookup_ready;
    logic       rsp_valid;
    logic       rsp_hit;
    icm_addr_t  rsp_icm_addr;
    phy_addr_t  rsp_phy_addr;
    logic       rsp_ready;

    // buffer write and tag status
    logic       buf_wen;
    req_tag_t   buf_tag;
    mr_head_t   buf_head;
    logic       tag_busy;

    // queue push
    logic       get_push;
    req_tag_t   get_tag;
    icm_addr_t  get_icm_addr;
    phy_addr_t  get_phy_addr;
    logic       get_full;

    mpt_req_ctl mpt_req_ctl_inst (
        .clk(clk), .rst(rst),
        .mr_req_valid(mr_req_valid), .mr_req_ready(mr_req_ready),
        .mr_req_tag(mr_req_tag), .mr_req_lkey(mr_req_lkey), .mr_req_head(mr_req_head),
        .tag_busy(tag_busy),
        .lookup_valid(lookup_valid), .lookup_idx(lookup_idx), .lookup_ready(lookup_ready),
        .rsp_valid(rsp_valid), .rsp_hit(rsp_hit),
        .rsp_icm_addr(rsp_icm_addr), .rsp_phy_addr(rsp_phy_addr), .rsp_ready(rsp_ready),
        .buf_wen(buf_wen), .buf_tag(buf_tag), .buf_head(buf_head),
        .get_push(get_push), .get_tag(get_tag),
        .get_icm_addr(get_icm_addr), .get_phy_addr(get_phy_addr), .get_full(get_full),
        .mr_req_err(mr_req_err)
    );

    icm_mapping_table icm_mapping_table_inst (
        .clk(clk), .rst(rst),
        .map_wr_en(map_wr_en), .map_wr_idx(map_wr_idx),
        .map_wr_phy_addr(map_wr_phy_addr), .map_wr_valid(map_wr_valid),
        .lookup_valid(lookup_valid), .lookup_idx(lookup_idx), .lookup_ready(lookup_ready),
        .rsp_valid(rsp_valid), .rsp_hit(rsp_hit),
        .rsp_icm_addr(rsp_icm_addr), .rsp_phy_addr(rsp_phy_addr), .rsp_ready(rsp_ready)
    );

    // busy query follows the incoming command tag
    mr_req_buffer mr_req_buffer_inst (
        .clk(clk), .rst(rst),
        .buf_wen(buf_wen), .buf_tag(buf_tag), .buf_head(buf_head),
        .query_tag(mr_req_tag), .tag_busy(tag_busy),
        .cpl_valid(cpl_valid), .cpl_tag(cpl_tag),
        .cpl_head_valid(cpl_head_valid), .cpl_head(cpl_head)
    );

    icm_get_queue icm_get_queue_inst (
        .clk(clk), .rst(rst),
        .get_push(get_push), .get_tag(get_tag),
        .get_icm_addr(get_icm_addr), .get_phy_addr(get_phy_addr), .get_full(get_full),
        .icm_get_valid(icm_get_valid), .icm_get_tag(icm_get_tag),
        .icm_get_icm_addr(icm_get_icm_addr), .icm_get_phy_addr(icm_get_phy_addr),
        .icm_get_ready(icm_get_ready)
    );

endmodule

`default_nettype wire

// ==== tb_mr_req.sv ====
/*
 * MR request engine testbench
 * directed tests against a model MPT table and a queue of expected get requests
 */
`timescale 1ns/1ps
`default_nettype none

`include "mr_cfg.svh"

module tb_mr_req import mr_pkg::*; ();

    localparam logic [31:0] LFSR_SEED  = 32'h6077_43b8;
    localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;
    localparam icm_addr_t   SLOT_BYTES = icm_addr_t'(1) << `MPT_SLOT_SIZE_LOG;
    localparam int VALID_ENTRIES = 56;
    localparam int STREAM_LEN    = 20;
    localparam int GET_LATENCY   = 4;
    // limit from the command count and two load cycles per table entry
    localparam int NUM_CMDS    = 30;
    localparam int CYCLE_LIMIT = 2 * `MPT_ENTRY_NUM + 40 * NUM_CMDS + 300;

    logic       clk;
    logic       rst;
    logic       mr_req_valid;
    logic       mr_req_ready;
    req_tag_t   mr_req_tag;
    lkey_t      mr_req_lkey;
    mr_head_t   mr_req_head;
    logic       mr_req_err;
    logic       map_wr_en;
    mpt_idx_t   map_wr_idx;
    phy_addr_t  map_wr_phy_addr;
    logic       map_wr_valid;
    logic       cpl_valid;
    req_tag_t   cpl_tag;
    logic       cpl_head_valid;
    mr_head_t   cpl_head;
    logic       icm_get_valid;
    req_tag_t   icm_get_tag;
    icm_addr_t  icm_get_icm_addr;
    phy_addr_t  icm_get_phy_addr;
    logic       icm_get_ready;

    // reference model
    phy_addr_t  model_phy [`MPT_ENTRY_NUM];
    logic       model_valid [`MPT_ENTRY_NUM];
    mr_head_t   head_model [`MR_TAG_NUM];
    logic       busy_model [`MR_TAG_NUM];

    // expected get requests in order
    req_tag_t   exp_tag [$];
    icm_addr_t  exp_icm [$];
    phy_addr_t  exp_phy [$];
    int         exp_cyc [$];

    logic [31:0] lfsr_q;
    logic [1:0]  ready_mode;
    logic        latency_check;
    int          cycle_cnt;
    int          checks;
    int          errors;
    int          err_seen;
    int          exp_err;

    mr_req_top mr_req_top_inst (
        .clk(clk), .rst(rst),
        .mr_req_valid(mr_req_valid), .mr_req_ready(mr_req_ready),
        .mr_req_tag(mr_req_tag), .mr_req_lkey(mr_req_lkey), .mr_req_head(mr_req_head),
        .mr_req_err(mr_req_err),
        .map_wr_en(map_wr_en), .map_wr_idx(map_wr_idx),
        .map_wr_phy_addr(map_wr_phy_addr), .map_wr_valid(map_wr_valid),
        .cpl_valid(cpl_valid), .cpl_tag(cpl_tag),
        .cpl_head_valid(cpl_head_valid), .cpl_head(cpl_head),
        .icm_get_valid(icm_get_valid), .icm_get_tag(icm_get_tag),
        .icm_get_icm_addr(icm_get_icm_addr), .icm_get_phy_addr(icm_get_phy_addr),
        .icm_get_ready(icm_get_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // cycle count and hang guard
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("checks %0d, errors %0d", checks, errors + 1);
            $display("Errors found");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // one lfsr step per bit
    task automatic draw_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    task automatic check_tag(input string name, input req_tag_t got, input req_tag_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_icm(input string name, input icm_addr_t got, input icm_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_phy(input string name, input phy_addr_t got, input phy_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_head(input string name, input mr_head_t got, input mr_head_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // a get request leaves at the next rising edge
    task automatic pop_check();
        int acc;
        if (exp_tag.size() == 0) begin
            errors++;
            $display("get request with tag %0h appeared at %0t with none outstanding",
                     icm_get_tag, $time);
        end else begin
            check_tag("icm_get_tag", icm_get_tag, exp_tag.pop_front());
            check_icm("icm_get_icm_addr", icm_get_icm_addr, exp_icm.pop_front());
            check_phy("icm_get_phy_addr", icm_get_phy_addr, exp_phy.pop_front());
            acc = exp_cyc.pop_front();
            if (latency_check && (cycle_cnt - acc) != GET_LATENCY) begin
                errors++;
                $display("get request arrived %0d cycles after acceptance instead of %0d",
                         cycle_cnt - acc, GET_LATENCY);
            end
        end
    endtask

    // icm cache side with ready low, high or random
    initial begin : get_consumer
        logic [63:0] r;
        icm_get_ready = 1'b0;
        forever begin
            @(negedge clk);
            case (ready_mode)
                2'd0: icm_get_ready = 1'b0;
                2'd1: icm_get_ready = 1'b1;
                default: begin
                    draw_bits(1, r);
                    icm_get_ready = r[0];
                end
            endcase
            #1;
            if (mr_req_err) begin
                err_seen++;
            end
            if (icm_get_valid && icm_get_ready) begin
                pop_check();
            end
        end
    end

    // mode changes away from the consumer's edge
    task automatic set_ready_mode(input logic [1:0] m);
        @(posedge clk);
        ready_mode = m;
        @(negedge clk);
    endtask

    task automatic load_entry(input mpt_idx_t idx, input phy_addr_t phy, input logic vld);
        @(negedge clk);
        map_wr_en       = 1'b1;
        map_wr_idx      = idx;
        map_wr_phy_addr = phy;
        map_wr_valid    = vld;
        model_phy[idx]   = phy;
        model_valid[idx] = vld;
        @(negedge clk);
        map_wr_en = 1'b0;
    endtask

    task automatic drive_cmd(input req_tag_t tag, input lkey_t lkey, input mr_head_t head);
        @(negedge clk);
        mr_req_valid = 1'b1;
        mr_req_tag   = tag;
        mr_req_lkey  = lkey;
        mr_req_head  = head;
    endtask

    // called on a falling edge with the command driven
    task automatic wait_accept();
        mpt_idx_t idx;
        int       acc;
        #1;
        while (!mr_req_ready) begin
            @(negedge clk);
            #1;
        end
        acc = cycle_cnt;
        idx = mr_req_lkey[`MPT_IDX_W-1:0];
        @(negedge clk);
        mr_req_valid = 1'b0;
        if (model_valid[idx]) begin
            // slot address is base plus index times slot size
            exp_tag.push_back(mr_req_tag);
            exp_icm.push_back(icm_addr_t'(`MPT_ICM_BASE) + icm_addr_t'(idx) * SLOT_BYTES);
            exp_phy.push_back(model_phy[idx]);
            exp_cyc.push_back(acc);
            head_model[mr_req_tag] = mr_req_head;
            busy_model[mr_req_tag] = 1'b1;
        end else begin
            exp_err++;
        end
    endtask

    task automatic send_cmd(input req_tag_t tag, input lkey_t lkey, input mr_head_t head);
        drive_cmd(tag, lkey, head);
        wait_accept();
    endtask

    // head returns one cycle after the completion
    task automatic complete_tag(input req_tag_t tag);
        @(negedge clk);
        cpl_valid = 1'b1;
        cpl_tag   = tag;
        @(negedge clk);
        cpl_valid = 1'b0;
        check_bit("cpl_head_valid", cpl_head_valid, busy_model[tag]);
        if (busy_model[tag]) begin
            check_head("cpl_head", cpl_head, head_model[tag]);
        end
        busy_model[tag] = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_tag.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic random_hit_lkey(output lkey_t k);
        logic [63:0] r;
        mpt_idx_t    idx;
        draw_bits(32, r);
        idx = mpt_idx_t'(int'(r[13:6]) % VALID_ENTRIES);
        k = {r[31:6], idx};
    endtask

    task automatic random_head(output mr_head_t h);
        logic [63:0] r;
        draw_bits(64, r);
        h = r;
    endtask

    task automatic load_table();
        logic [63:0] r;
        for (int i = 0; i < `MPT_ENTRY_NUM; i++) begin
            draw_bits(64, r);
            load_entry(mpt_idx_t'(i), r, i < VALID_ENTRIES);
        end
    endtask

    task automatic single_hit_test();
        lkey_t    k;
        mr_head_t h;
        random_hit_lkey(k);
        random_head(h);
        latency_check = 1'b1;
        send_cmd(5'd5, k, h);
        wait_drain();
        latency_check = 1'b0;
        complete_tag(5'd5);
    endtask

    task automatic miss_test();
        logic [63:0] r;
        mr_head_t    h;
        // load then invalidate entry 60
        draw_bits(64, r);
        load_entry(6'd60, r, 1'b1);
        load_entry(6'd60, r, 1'b0);
        draw_bits(32, r);
        random_head(h);
        // ready low keeps a stray get request visible on icm_get_valid
        set_ready_mode(2'd0);
        send_cmd(5'd9, {r[31:6], 6'd60}, h);
        while (err_seen != exp_err) begin
            @(negedge clk);
        end
        repeat (6) @(negedge clk);
        check_bit("icm_get_valid", icm_get_valid, 1'b0);
        check_bit("mr_req_ready", mr_req_ready, 1'b1);
        set_ready_mode(2'd1);
        complete_tag(5'd9);
    endtask

    task automatic backpressure_test();
        lkey_t    k;
        mr_head_t h;
        set_ready_mode(2'd0);
        // four fill the fifo and the fifth waits in the controller
        for (int i = 0; i <= `GET_FIFO_DEPTH; i++) begin
            random_hit_lkey(k);
            random_head(h);
            send_cmd(req_tag_t'(16 + i), k, h);
        end
        random_hit_lkey(k);
        random_head(h);
        drive_cmd(req_tag_t'(16 + `GET_FIFO_DEPTH + 1), k, h);
        repeat (8) begin
            #1;
            check_bit("mr_req_ready", mr_req_ready, 1'b0);
            check_bit("icm_get_valid", icm_get_valid, 1'b1);
            @(negedge clk);
        end
        set_ready_mode(2'd1);
        wait_accept();
        wait_drain();
        for (int i = 0; i <= `GET_FIFO_DEPTH + 1; i++) begin
            complete_tag(req_tag_t'(16 + i));
        end
    endtask

    task automatic busy_tag_test();
        lkey_t    k;
        mr_head_t h;
        random_hit_lkey(k);
        random_head(h);
        send_cmd(5'd3, k, h);
        wait_drain();
        // same tag again is held off until the completion
        random_hit_lkey(k);
        random_head(h);
        drive_cmd(5'd3, k, h);
        repeat (6) begin
            #1;
            check_bit("mr_req_ready", mr_req_ready, 1'b0);
            @(negedge clk);
        end
        complete_tag(5'd3);
        wait_accept();
        wait_drain();
        complete_tag(5'd3);
    endtask

    task automatic stream_test();
        lkey_t    lkeys [STREAM_LEN];
        mr_head_t heads [STREAM_LEN];
        // all stimulus drawn before the consumer starts drawing
        for (int i = 0; i < STREAM_LEN; i++) begin
            random_hit_lkey(lkeys[i]);
            random_head(heads[i]);
        end
        set_ready_mode(2'd2);
        for (int i = 0; i < STREAM_LEN; i++) begin
            send_cmd(req_tag_t'(i), lkeys[i], heads[i]);
        end
        wait_drain();
        set_ready_mode(2'd1);
        for (int i = 0; i < STREAM_LEN; i++) begin
            complete_tag(req_tag_t'(i));
        end
    endtask

    initial begin
        rst             = 1'b1;
        mr_req_valid    = 1'b0;
        mr_req_tag      = '0;
        mr_req_lkey     = '0;
        mr_req_head     = '0;
        map_wr_en       = 1'b0;
        map_wr_idx      = '0;
        map_wr_phy_addr = '0;
        map_wr_valid    = 1'b0;
        cpl_valid       = 1'b0;
        cpl_tag         = '0;
        lfsr_q          = LFSR_SEED;
        ready_mode      = 2'd1;
        latency_check   = 1'b0;
        cycle_cnt       = 0;
        checks          = 0;
        errors          = 0;
        err_seen        = 0;
        exp_err         = 0;
        for (int i = 0; i < `MPT_ENTRY_NUM; i++) begin
            model_valid[i] = 1'b0;
        end
        for (int i = 0; i < `MR_TAG_NUM; i++) begin
            busy_model[i] = 1'b0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // idle state after reset
        @(negedge clk);
        check_bit("mr_req_ready", mr_req_ready, 1'b1);
        check_bit("icm_get_valid", icm_get_valid, 1'b0);
        check_bit("cpl_head_valid", cpl_head_valid, 1'b0);
        check_bit("mr_req_err", mr_req_err, 1'b0);
        load_table();
        single_hit_test();
        miss_test();
        backpressure_test();
        busy_tag_test();
        stream_test();
        repeat (4) @(negedge clk);
        checks++;
        if (err_seen != exp_err) begin
            errors++;
            $display("mr_req_err pulsed %0d times, expected %0d", err_seen, exp_err);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
mr_pkg.sv
icm_mapping_table.sv
mr_req_buffer.sv
icm_get_queue.sv
mpt_req_ctl.sv
mr_req_top.sv
tb_mr_req.sv

// ==== Makefile ====
# Verilator flow for the MR request engine
TOP = tb_mr_req

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f src.f --top-module mr_req_top
	verilator --lint-only --timing -f src.f --top-module $(TOP)

# pass only when the testbench prints its pass line
sim:
	verilator --binary --timing -f src.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
